//--- Makefile
# Verilator flow for the processor host testbench
VERILATOR ?= verilator
TOP       ?= tb_proc_host
RTL_TOP   ?= proc_host_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
FAIL_MSG  := \*\* FAIL \*\*

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -o $(TOP)

# Fails on a nonzero exit status or on the fail message in the log
sim: build
	@./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "Simulator exited with status $$status"; exit 1; fi; \
	if grep -q '$(FAIL_MSG)' $(LOG); then echo "Failure reported in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rtl/proc_alu.sv
/* Combinational ALU with zero, negative, carry and overflow flags */
`timescale 1ns/1ps

module proc_alu (
    input  proc_pkg::alu_op_e op,
    input  proc_pkg::word_t   a,
    input  proc_pkg::word_t   b,
    output proc_pkg::word_t   result,
    output proc_pkg::flags_t  flags
);
    import proc_pkg::*;

    logic [WORD_W:0] sum;  // One extra bit for carry out
    word_t           res;
    logic            carry;
    logic            ovf;

    always_comb begin
        sum   = '0;
        res   = '0;
        carry = 1'b0;
        ovf   = 1'b0;
        case (op)
            ADD: begin
                sum   = {1'b0, a} + {1'b0, b};
                res   = sum[WORD_W-1:0];
                carry = sum[WORD_W];
                ovf   = (a[WORD_W-1] == b[WORD_W-1]) && (res[WORD_W-1] != a[WORD_W-1]);
            end
            SUB: begin
                // a + ~b + 1, carry out set means no borrow
                sum   = {1'b0, a} + {1'b0, ~b} + {{WORD_W{1'b0}}, 1'b1};
                res   = sum[WORD_W-1:0];
                carry = sum[WORD_W];
                ovf   = (a[WORD_W-1] != b[WORD_W-1]) && (res[WORD_W-1] != a[WORD_W-1]);
            end
            AND:     res = a & b;
            OR:      res = a | b;
            XOR:     res = a ^ b;
            PASS_B:  res = b;
            default: res = '0;
        endcase
    end

    assign result  = res;
    assign flags.z = (res == '0);
    assign flags.n = res[WORD_W-1];
    assign flags.c = carry;  // Zero for logic ops
    assign flags.v = ovf;

endmodule

//--- rtl/proc_decoder.sv
/* Opcode decoder producing ALU operation and control bits */
`timescale 1ns/1ps

module proc_decoder (
    input  proc_pkg::opcode_t   opcode,
    output proc_pkg::dec_ctrl_t ctrl
);
    import proc_pkg::*;

    logic alu_class;

    assign alu_class = (opcode == OP_ADD) || (opcode == OP_SUB) ||
                       (opcode == OP_AND) || (opcode == OP_OR)  ||
                       (opcode == OP_XOR);

    always_comb begin
        ctrl = '0;  // NOP and undefined opcodes
        case (opcode)
            OP_ADD: ctrl.alu_op = ADD;
            OP_SUB: ctrl.alu_op = SUB;
            OP_AND: ctrl.alu_op = AND;
            OP_OR:  ctrl.alu_op = OR;
            OP_XOR: ctrl.alu_op = XOR;
            OP_LOAD: begin
                ctrl.alu_op          = PASS_B;
                ctrl.use_imm         = 1'b1;
                ctrl.reg_write       = 1'b1;
                ctrl.result_from_alu = 1'b1;  // Flags left alone
            end
            OP_STORE: begin
                // rb_idx carries ra here, so B is the register to read out
                ctrl.alu_op          = PASS_B;
                ctrl.result_from_alu = 1'b1;
            end
            default: begin
                ctrl.alu_op = ADD;
            end
        endcase

        // Register-register ops write back to ra and update flags
        if (alu_class) begin
            ctrl.reg_write       = 1'b1;
            ctrl.flags_write     = 1'b1;
            ctrl.result_from_alu = 1'b1;
        end
    end

endmodule

//--- rtl/proc_host_top.sv
/* Processor host top level, bus slave, sequencer, decoder, ALU
   and register file */
`timescale 1ns/1ps

module proc_host_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               cyc,
    input  logic               stb,
    input  logic               we,
    input  proc_pkg::wb_addr_t adr,
    input  proc_pkg::word_t    dat_w,
    output proc_pkg::word_t    dat_r,
    output logic               ack
);
    import proc_pkg::*;

    logic      launch;
    instr_t    instr;
    logic      busy;
    logic      done;
    word_t     result;
    flags_t    flags;
    reg_idx_t  ra_idx;
    reg_idx_t  rb_idx;
    opcode_t   opcode;
    dec_ctrl_t ctrl;
    word_t     ra_data;
    word_t     rb_data;
    word_t     alu_b;
    word_t     alu_result;
    flags_t    alu_flags;
    logic      rf_we;
    reg_idx_t  rf_wr_idx;
    word_t     rf_wr_data;

    // Slave copy of the instruction only changes on launch, so imm matches the sequencer
    assign alu_b = ctrl.use_imm ? {{(WORD_W-IMM_W){1'b0}}, instr.imm} : rb_data;

    proc_wb_slave u_wb_slave (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .dat_r(dat_r), .ack(ack), .launch(launch), .instr(instr),
        .busy(busy), .done(done), .result(result), .flags(flags)
    );

    proc_sequencer u_sequencer (
        .clk(clk), .rst(rst), .launch(launch), .instr(instr),
        .busy(busy), .done(done), .result(result), .flags(flags),
        .ra_idx(ra_idx), .rb_idx(rb_idx), .opcode(opcode), .ctrl(ctrl),
        .alu_result(alu_result), .alu_flags(alu_flags),
        .rf_we(rf_we), .rf_wr_idx(rf_wr_idx), .rf_wr_data(rf_wr_data)
    );

    proc_decoder u_decoder (
        .opcode(opcode),
        .ctrl(ctrl)
    );

    proc_alu u_alu (
        .op(ctrl.alu_op), .a(ra_data), .b(alu_b),
        .result(alu_result), .flags(alu_flags)
    );

    proc_regfile u_regfile (
        .clk(clk), .rst(rst), .ra_idx(ra_idx), .rb_idx(rb_idx),
        .ra_data(ra_data), .rb_data(rb_data),
        .we(rf_we), .wr_idx(rf_wr_idx), .wr_data(rf_wr_data)
    );

endmodule

//--- rtl/proc_pkg.sv
/* Shared widths, opcodes, register map, instruction and control structs,
   ALU flags and sequencer state type for the processor host */
package proc_pkg;

    localparam int WORD_W    = 32;
    localparam int REG_IDX_W = 4;
    localparam int REG_COUNT = 16;
    localparam int OPCODE_W  = 6;
    localparam int IMM_W     = 18;
    localparam int WB_ADDR_W = 2;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [OPCODE_W-1:0]  opcode_t;
    typedef logic [WB_ADDR_W-1:0] wb_addr_t;

    // Opcodes, anything else executes as NOP
    localparam opcode_t OP_ADD   = 6'd1;
    localparam opcode_t OP_SUB   = 6'd2;
    localparam opcode_t OP_AND   = 6'd3;
    localparam opcode_t OP_OR    = 6'd4;
    localparam opcode_t OP_XOR   = 6'd5;
    localparam opcode_t OP_LOAD  = 6'd6;
    localparam opcode_t OP_STORE = 6'd7;

    // Bus register map
    localparam wb_addr_t ADDR_INSTR  = 2'd0;
    localparam wb_addr_t ADDR_RESULT = 2'd1;
    localparam wb_addr_t ADDR_STATUS = 2'd2;

    // Status word layout
    localparam int STATUS_BUSY_BIT  = 0;
    localparam int STATUS_DONE_BIT  = 1;
    localparam int STATUS_FLAGS_LSB = 4;

    typedef struct packed {
        opcode_t              opcode;  // [31:26]
        reg_idx_t             ra;      // First source and destination
        reg_idx_t             rb;      // Second source
        logic [IMM_W-1:0]     imm;     // Zero-extended on LOAD
    } instr_t;

    typedef enum logic [2:0] {
        ADD    = 3'd0,
        SUB    = 3'd1,
        AND    = 3'd2,
        OR     = 3'd3,
        XOR    = 3'd4,
        PASS_B = 3'd5
    } alu_op_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;          // Operand B from immediate
        logic    reg_write;
        logic    flags_write;
        logic    result_from_alu;  // Zero result when clear
    } dec_ctrl_t;

    typedef struct packed {
        logic z;
        logic n;
        logic c;
        logic v;
    } flags_t;

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        DECODE  = 2'd1,
        EXECUTE = 2'd2,
        DONE    = 2'd3
    } seq_state_e;

endpackage

//--- rtl/proc_regfile.sv
/* Register file, 16 words of 32 bits,
   two combinational read ports and one clocked write port */
`timescale 1ns/1ps

module proc_regfile (
    input  logic              clk,
    input  logic              rst,
    input  proc_pkg::reg_idx_t ra_idx,
    input  proc_pkg::reg_idx_t rb_idx,
    output proc_pkg::word_t    ra_data,
    output proc_pkg::word_t    rb_data,
    input  logic              we,
    input  proc_pkg::reg_idx_t wr_idx,
    input  proc_pkg::word_t    wr_data
);
    import proc_pkg::*;

    word_t regs [REG_COUNT];

    // Whole file cleared so programs start from a known state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign ra_data = regs[ra_idx];  // Async read
    assign rb_data = regs[rb_idx];

endmodule

//--- rtl/proc_sequencer.sv
/* Instruction sequencer FSM, idle through decode and execute to done,
   with result, flags and register write-back control */
`timescale 1ns/1ps

module proc_sequencer (
    input  logic                clk,
    input  logic                rst,
    input  logic                launch,
    input  proc_pkg::instr_t    instr,
    output logic                busy,
    output logic                done,
    output proc_pkg::word_t     result,
    output proc_pkg::flags_t    flags,
    output proc_pkg::reg_idx_t  ra_idx,
    output proc_pkg::reg_idx_t  rb_idx,
    output proc_pkg::opcode_t   opcode,
    input  proc_pkg::dec_ctrl_t ctrl,
    input  proc_pkg::word_t     alu_result,
    input  proc_pkg::flags_t    alu_flags,
    output logic                rf_we,
    output proc_pkg::reg_idx_t  rf_wr_idx,
    output proc_pkg::word_t     rf_wr_data
);
    import proc_pkg::*;

    seq_state_e state;
    seq_state_e state_nxt;
    instr_t     ir;       // Instruction held through execution
    logic       accept;

    assign accept = launch && (state == IDLE);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (launch) state_nxt = DECODE;
            DECODE:  state_nxt = EXECUTE;
            EXECUTE: state_nxt = DONE;
            DONE:    state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= IDLE;
            done   <= 1'b0;
            result <= '0;
            flags  <= '0;
        end else begin
            state <= state_nxt;
            if (accept) begin
                done <= 1'b0;  // Cleared by the next launch
            end
            if (state == EXECUTE) begin
                result <= ctrl.result_from_alu ? alu_result : '0;
                done   <= 1'b1;
                if (ctrl.flags_write) begin
                    flags <= alu_flags;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ir <= instr;
        end
    end

    assign busy   = (state != IDLE);
    assign opcode = ir.opcode;
    assign ra_idx = ir.ra;
    assign rb_idx = (ir.opcode == OP_STORE) ? ir.ra : ir.rb;  // STORE reads ra via port B

    // Write-back lands on the edge that ends EXECUTE
    assign rf_we      = (state == EXECUTE) && ctrl.reg_write;
    assign rf_wr_idx  = ir.ra;
    assign rf_wr_data = alu_result;

endmodule

//--- rtl/proc_wb_slave.sv
/* Wishbone classic slave with instruction, result and status registers,
   single-cycle ack and stall of instruction writes while busy */
`timescale 1ns/1ps

module proc_wb_slave (
    input  logic               clk,
    input  logic               rst,
    input  logic               cyc,
    input  logic               stb,
    input  logic               we,
    input  proc_pkg::wb_addr_t adr,
    input  proc_pkg::word_t    dat_w,
    output proc_pkg::word_t    dat_r,
    output logic               ack,
    output logic               launch,
    output proc_pkg::instr_t   instr,
    input  logic               busy,
    input  logic               done,
    input  proc_pkg::word_t    result,
    input  proc_pkg::flags_t   flags
);
    import proc_pkg::*;

    logic  req;
    logic  instr_wr;
    logic  accept;
    word_t status;
    word_t rd_mux;

    assign req      = cyc && stb && !ack;  // New cycle, not the one being acked
    assign instr_wr = we && (adr == ADDR_INSTR);
    assign accept   = req && !(instr_wr && busy);  // Back-pressure while executing

    always_comb begin
        status                                       = '0;
        status[STATUS_BUSY_BIT]                      = busy;
        status[STATUS_DONE_BIT]                      = done;
        status[STATUS_FLAGS_LSB +: $bits(flags_t)]   = flags;
    end

    always_comb begin
        case (adr)
            ADDR_INSTR:  rd_mux = instr;  // Last launched instruction
            ADDR_RESULT: rd_mux = result;
            ADDR_STATUS: rd_mux = status;
            default:     rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack    <= 1'b0;
            launch <= 1'b0;
            instr  <= '0;
        end else begin
            ack    <= accept;
            launch <= accept && instr_wr;  // Same cycle as the ack
            if (accept && instr_wr) begin
                instr <= dat_w;
            end
        end
    end

    // Read data valid in the ack cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            dat_r <= rd_mux;
        end
    end

endmodule

//--- tb/tb_proc_host.sv
/* Testbench for the processor host with Wishbone bus tasks,
   reference model, compare tasks and timeout */
`timescale 1ns/1ps

module tb_proc_host;
    import proc_pkg::*;

    // About 400 instructions at roughly 30 cycles each, plus margin
    localparam int     TIMEOUT_CYCLES = 20000;
    localparam longint INT_MAX        = 64'sd2147483647;
    localparam longint INT_MIN        = -64'sd2147483648;

    typedef struct packed {
        word_t    result;
        flags_t   flags;
        logic     wr_en;
        reg_idx_t wr_idx;
    } expect_t;

    logic     clk = 1'b0;
    logic     rst;
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    word_t    dat_w;
    word_t    dat_r;
    logic     ack;

    word_t  model_regs [REG_COUNT];
    flags_t model_flags;
    word_t  model_result;
    instr_t last_instr;
    int     cycle_count = 0;
    int     last_ack_cycle;
    int     checks = 0;
    int     errors_value = 0;
    int     errors_other = 0;

    proc_host_top u_proc_host_top (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .dat_r(dat_r), .ack(ack)
    );

    always #4 clk = ~clk;  // 8 ns period

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: run hung, no completion within %0d cycles", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic instr_t make_instr(input opcode_t op, input reg_idx_t ra,
                                          input reg_idx_t rb, input word_t imm);
        instr_t ins;
        ins.opcode = op;
        ins.ra     = ra;
        ins.rb     = rb;
        ins.imm    = imm[IMM_W-1:0];
        return ins;
    endfunction

    // Expected outcome of one instruction against the model state
    function automatic expect_t model_exec(input instr_t ins, input word_t regs [REG_COUNT],
                                           input flags_t prev);
        expect_t e;
        flags_t  fl;
        word_t   a;
        word_t   b;
        longint  wide;
        logic    is_alu;
        a        = regs[ins.ra];
        b        = regs[ins.rb];
        fl       = '0;
        is_alu   = 1'b1;
        e.result = '0;
        e.flags  = prev;
        e.wr_en  = 1'b0;
        e.wr_idx = ins.ra;
        case (ins.opcode)
            OP_ADD: begin
                wide     = longint'(a) + longint'(b);
                e.result = wide[31:0];
                fl.c     = wide[32];
                wide     = longint'($signed(a)) + longint'($signed(b));
                fl.v     = (wide > INT_MAX) || (wide < INT_MIN);
            end
            OP_SUB: begin
                e.result = a - b;
                fl.c     = (a >= b);  // No borrow
                wide     = longint'($signed(a)) - longint'($signed(b));
                fl.v     = (wide > INT_MAX) || (wide < INT_MIN);
            end
            OP_AND: e.result = a & b;
            OP_OR:  e.result = a | b;
            OP_XOR: e.result = a ^ b;
            OP_LOAD: begin
                is_alu   = 1'b0;
                e.result = {{(WORD_W-IMM_W){1'b0}}, ins.imm};
                e.wr_en  = 1'b1;
            end
            OP_STORE: begin
                is_alu   = 1'b0;
                e.result = a;
            end
            default: is_alu = 1'b0;
        endcase
        if (is_alu) begin
            fl.z    = (e.result == '0);
            fl.n    = e.result[31];
            e.flags = fl;
            e.wr_en = 1'b1;
        end
        return e;
    endfunction

    task automatic apply_model(input expect_t e);
        if (e.wr_en) begin
            model_regs[e.wr_idx] = e.result;
        end
        model_flags  = e.flags;
        model_result = e.result;
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors_value++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flags(input string name, input flags_t exp, input flags_t act);
        checks++;
        if (act !== exp) begin
            errors_value++;
            $display("FAILED %s: expected zncv %b, actual zncv %b", name, exp, act);
        end
    endtask

    task automatic wait_ack();
        do @(negedge clk); while (ack !== 1'b1);
        last_ack_cycle = cycle_count;
    endtask

    task automatic wb_write(input wb_addr_t addr, input word_t data);
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= 1'b1;
        adr   <= addr;
        dat_w <= data;
        wait_ack();
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic wb_read(input wb_addr_t addr, output word_t data);
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we  <= 1'b0;
        adr <= addr;
        wait_ack();
        data = dat_r;  // Valid in the ack cycle
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
    endtask

    task automatic collect_result(input string name, input expect_t e);
        word_t st;
        word_t res;
        do wb_read(ADDR_STATUS, st); while (st[STATUS_DONE_BIT] !== 1'b1);
        wb_read(ADDR_RESULT, res);
        check_word($sformatf("%s result", name), e.result, res);
        check_flags($sformatf("%s flags", name), e.flags,
                    flags_t'(st[STATUS_FLAGS_LSB +: $bits(flags_t)]));
    endtask

    task automatic run_instr(input string name, input instr_t ins);
        expect_t e;
        e = model_exec(ins, model_regs, model_flags);
        apply_model(e);
        last_instr = ins;
        wb_write(ADDR_INSTR, ins);
        collect_result(name, e);
    endtask

    initial begin
        word_t    rd;
        word_t    exp_status;
        instr_t   ins_a;
        instr_t   ins_b;
        expect_t  e;
        int       ack_first;
        reg_idx_t r;
        void'($urandom(85));
        rst   <= 1'b1;
        cyc   <= 1'b0;
        stb   <= 1'b0;
        we    <= 1'b0;
        adr   <= '0;
        dat_w <= '0;
        for (int i = 0; i < REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        model_flags  = '0;
        model_result = '0;
        last_instr   = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // Reset state
        wb_read(ADDR_STATUS, rd);
        check_word("reset status", '0, rd);
        wb_read(ADDR_RESULT, rd);
        check_word("reset result", '0, rd);
        for (int i = 0; i < REG_COUNT; i++) begin
            run_instr($sformatf("reset store r%0d", i), make_instr(OP_STORE, reg_idx_t'(i),
                      reg_idx_t'($urandom_range(15)), $urandom()));
        end

        // LOAD then STORE of the same register
        run_instr("flag preset", make_instr(OP_XOR, 4'd0, 4'd0, '0));  // Z set beforehand
        for (int i = 0; i < 24; i++) begin
            r = reg_idx_t'($urandom_range(15));
            run_instr($sformatf("load %0d", i), make_instr(OP_LOAD, r, '0, $urandom()));
            run_instr($sformatf("store %0d", i), make_instr(OP_STORE, r, '0, '0));
        end

        // Random ALU ops chaining through write-back
        for (int i = 0; i < REG_COUNT; i++) begin
            run_instr("operand load", make_instr(OP_LOAD, reg_idx_t'(i), '0, $urandom()));
        end
        for (int i = 0; i < 200; i++) begin
            run_instr($sformatf("alu %0d", i),
                      make_instr(opcode_t'(1 + $urandom_range(4)),
                                 reg_idx_t'($urandom_range(15)),
                                 reg_idx_t'($urandom_range(15)), $urandom()));
        end

        // Doubling up to 0x80000000 for overflow, carry and zero cases
        run_instr("ovf load r1", make_instr(OP_LOAD, 4'd1, '0, 32'd1));
        for (int i = 0; i < 31; i++) begin
            run_instr($sformatf("double %0d", i), make_instr(OP_ADD, 4'd1, 4'd1, '0));
        end
        run_instr("ovf load r2", make_instr(OP_LOAD, 4'd2, '0, 32'd1));
        run_instr("ovf clear r3", make_instr(OP_LOAD, 4'd3, '0, '0));
        run_instr("ovf copy r3", make_instr(OP_OR, 4'd3, 4'd1, '0));
        run_instr("sub overflow", make_instr(OP_SUB, 4'd3, 4'd2, '0));
        run_instr("add overflow", make_instr(OP_ADD, 4'd3, 4'd2, '0));
        run_instr("add carry zero", make_instr(OP_ADD, 4'd1, 4'd1, '0));
        run_instr("sub borrow", make_instr(OP_SUB, 4'd1, 4'd2, '0));
        run_instr("xor zero", make_instr(OP_XOR, 4'd4, 4'd4, '0));

        // NOP and undefined opcodes leave registers and flags alone
        run_instr("flag setup", make_instr(OP_SUB, 4'd1, 4'd2, '0));  // N and C set
        run_instr("nop", make_instr('0, reg_idx_t'($urandom_range(15)), 4'd1, $urandom()));
        for (int i = 0; i < 12; i++) begin
            run_instr($sformatf("undefined %0d", i),
                      make_instr(opcode_t'(8 + $urandom_range(55)),
                                 reg_idx_t'($urandom_range(15)),
                                 reg_idx_t'($urandom_range(15)), $urandom()));
        end
        for (int i = 0; i < REG_COUNT; i++) begin
            run_instr($sformatf("after nop r%0d", i),
                      make_instr(OP_STORE, reg_idx_t'(i), '0, '0));
        end

        // Second write must stall until the first instruction finishes
        ins_a = make_instr(OP_ADD, 4'd2, 4'd3, '0);
        ins_b = make_instr(OP_SUB, 4'd5, 4'd2, '0);
        e = model_exec(ins_a, model_regs, model_flags);
        apply_model(e);
        e = model_exec(ins_b, model_regs, model_flags);
        apply_model(e);
        wb_write(ADDR_INSTR, ins_a);
        ack_first = last_ack_cycle;
        wb_write(ADDR_INSTR, ins_b);
        last_instr = ins_b;
        if (last_ack_cycle - ack_first < 4) begin
            errors_other++;
            $display("ERROR: second instruction acknowledged %0d cycles after the first",
                     last_ack_cycle - ack_first);
        end
        collect_result("back-pressure", e);

        // Read-only and unused addresses
        wb_write(ADDR_RESULT, $urandom());
        wb_write(ADDR_STATUS, $urandom());
        wb_write(2'd3, $urandom());
        exp_status                                     = '0;
        exp_status[STATUS_DONE_BIT]                    = 1'b1;
        exp_status[STATUS_FLAGS_LSB +: $bits(flags_t)] = model_flags;
        wb_read(ADDR_RESULT, rd);
        check_word("result after write", model_result, rd);
        wb_read(ADDR_STATUS, rd);
        check_word("status after write", exp_status, rd);
        wb_read(ADDR_INSTR, rd);
        check_word("instr readback", last_instr, rd);
        wb_read(2'd3, rd);
        check_word("unused address", '0, rd);
        run_instr("store after writes", make_instr(OP_STORE, 4'd5, '0, '0));

        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 checks, errors_value, errors_other);
        if (errors_value == 0 && errors_other == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- vlog.f
rtl/proc_pkg.sv
rtl/proc_regfile.sv
rtl/proc_decoder.sv
rtl/proc_alu.sv
rtl/proc_sequencer.sv
rtl/proc_wb_slave.sv
rtl/proc_host_top.sv
tb/tb_proc_host.sv
